//--- arbiter.f
verilog/noc_pkg.sv
verilog/route_register.sv
verilog/rr_priority_register.sv
verilog/rr_output_arbiter.sv
verilog/arbiter.sv
bench/arbiter_checker.sv
bench/arbiter_tb.sv

//--- bench/arbiter_checker.sv
`timescale 1ns/1ns

module arbiter_checker
	import noc_pkg::*;
(
	input  logic                           clk,
	input  logic                           reset_i,
	input  logic [ADDR_W-1:0]              router_i,
	input  logic [NUM_PORTS*ADDR_W-1:0]    header_i,
	input  logic [NUM_PORTS-1:0]           write_i,
	input  logic [NUM_PORTS-1:0]           release_i,
	input  logic [NUM_PORTS-1:0]           change_order_i,
	input  logic [NUM_PORTS*NUM_PORTS-1:0] grant_i,
	input  logic [NUM_PORTS-1:0]           to_cs_i,
	input  logic                           exp_valid_i,
	input  logic [NUM_PORTS*NUM_PORTS-1:0] exp_grant_i,
	input  logic [8*12-1:0]                test_name_i,
	output int                             check_count_o,
	output int                             error_count_o
);

	logic [PORT_CODE_W-1:0]         route [NUM_PORTS];
	logic [PORT_CODE_W-1:0]         pointer [NUM_PORTS];
	logic                           model_ready;
	logic                           was_reset;
	logic                           pend_valid;
	logic [NUM_PORTS*NUM_PORTS-1:0] pend_grant;
	logic [8*12-1:0]                pend_name;

	initial begin
		model_ready   = 1'b0;
		was_reset     = 1'b1;
		pend_valid    = 1'b0;
		check_count_o = 0;
		error_count_o = 0;
	end

	// YX order, Y first, then X, else local.
	function automatic logic [PORT_CODE_W-1:0] expected_route(
		input logic [ADDR_W-1:0] router,
		input logic [ADDR_W-1:0] header
	);
		if (header[ADDR_W-1 -: COORD_W] > router[ADDR_W-1 -: COORD_W])
			return PORT_S;
		if (header[ADDR_W-1 -: COORD_W] < router[ADDR_W-1 -: COORD_W])
			return PORT_N;
		if (header[COORD_W-1:0] > router[COORD_W-1:0])
			return PORT_E;
		if (header[COORD_W-1:0] < router[COORD_W-1:0])
			return PORT_W;
		return PORT_L;
	endfunction

	// Winning input of output q, or -1 when nobody asks.
	function automatic int winner(input int q);
		int idx;
		for (int k = 0; k < NUM_PORTS; k++) begin
			idx = (int'(pointer[q]) + k) % NUM_PORTS;
			if (route[idx] == PORT_CODE_W'(q) && idx != q)
				return idx;
		end
		return -1;
	endfunction

	function automatic logic [7:0] port_name(input int q);
		case (q)
			0:       return "N";
			1:       return "S";
			2:       return "W";
			3:       return "E";
			default: return "L";
		endcase
	endfunction

	// ########################################
	// Reference model, follows the inputs on every rising edge.
	always @(posedge clk) begin : model_update
		int w;
		if (reset_i) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				route[p] = PORT_NONE;
				pointer[p] = '0;
			end
			model_ready = 1'b1;
		end else begin
			// Pointers step on the grant from before this edge.
			for (int q = 0; q < NUM_PORTS; q++) begin
				if (change_order_i[q]) begin
					w = winner(q);
					if (w < 0)
						w = int'(pointer[q]);
					pointer[q] = PORT_CODE_W'((w + 1) % NUM_PORTS);
				end
			end
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (write_i[p])
					route[p] = expected_route(router_i, header_i[p*ADDR_W +: ADDR_W]);
				else if (release_i[p])
					route[p] = PORT_NONE;
			end
		end
		was_reset  = reset_i;
		pend_valid = exp_valid_i;
		pend_grant = exp_grant_i;
		pend_name  = test_name_i;
	end

	// ########################################
	// Outputs are compared half a cycle after the edge.
	always @(negedge clk) begin : compare
		logic [NUM_PORTS-1:0] act_g;
		logic [NUM_PORTS-1:0] exp_g;
		int w;
		if (model_ready && !was_reset) begin
			for (int q = 0; q < NUM_PORTS; q++) begin
				act_g = grant_i[q*NUM_PORTS +: NUM_PORTS];
				exp_g = '0;
				w = winner(q);
				if (w >= 0)
					exp_g[w] = 1'b1;
				check_count_o++;
				if (act_g !== exp_g) begin
					$display("[ERROR] %s: output %s grant expected %b, actual %b",
						pend_name, port_name(q), exp_g, act_g);
					error_count_o++;
				end
				if (pend_valid && act_g !== pend_grant[q*NUM_PORTS +: NUM_PORTS]) begin
					$display("[ERROR] %s: output %s table grant expected %b, actual %b",
						pend_name, port_name(q), pend_grant[q*NUM_PORTS +: NUM_PORTS], act_g);
					error_count_o++;
				end
				if ((act_g & (act_g - 1'b1)) != '0) begin
					$display("%s: grant of output %s has more than one bit set (%b)",
						pend_name, port_name(q), act_g);
					error_count_o++;
				end
				if (to_cs_i[q] !== (|act_g)) begin
					$display("%s: to_cs of output %s does not agree with its grant",
						pend_name, port_name(q));
					error_count_o++;
				end
			end
		end
	end

endmodule

//--- bench/arbiter_tb.sv
`timescale 1ns/1ns

module arbiter_tb
	import noc_pkg::*;
();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS     = 18;
	localparam int NUM_RANDOM   = 200;
	localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_ROWS + NUM_RANDOM + 20) * CLK_PERIOD;

	logic                           clk;
	logic                           reset;
	logic [ADDR_W-1:0]              router;
	logic [NUM_PORTS*ADDR_W-1:0]    headers;
	logic [NUM_PORTS-1:0]           wr;
	logic [NUM_PORTS-1:0]           rel;
	logic [NUM_PORTS-1:0]           co;
	wire  [NUM_PORTS*NUM_PORTS-1:0] grants;
	wire  [NUM_PORTS-1:0]           to_cs;
	logic                           exp_valid;
	logic [NUM_PORTS*NUM_PORTS-1:0] exp_grant;
	logic [8*12-1:0]                test_name;
	logic [31:0]                    rng_state;
	int                             check_count;
	int                             error_count;
	int                             row_fill;

	logic [8*12-1:0]                tbl_name   [NUM_ROWS];
	logic [ADDR_W-1:0]              tbl_router [NUM_ROWS];
	logic [NUM_PORTS*ADDR_W-1:0]    tbl_hdr    [NUM_ROWS];
	logic [NUM_PORTS-1:0]           tbl_wr     [NUM_ROWS];
	logic [NUM_PORTS-1:0]           tbl_rel    [NUM_ROWS];
	logic [NUM_PORTS-1:0]           tbl_co     [NUM_ROWS];
	logic [NUM_PORTS*NUM_PORTS-1:0] tbl_exp    [NUM_ROWS];

	always #(CLK_PERIOD / 2) clk = ~clk;

	arbiter i_arbiter (
		.clk(clk), .reset_i(reset), .yx_addr_router_i(router),
		.yx_n_addr_header_i(headers[7:0]), .yx_s_addr_header_i(headers[15:8]),
		.yx_w_addr_header_i(headers[23:16]), .yx_e_addr_header_i(headers[31:24]),
		.yx_l_addr_header_i(headers[39:32]),
		.nhr_n_write_i(wr[PORT_N]), .nhr_s_write_i(wr[PORT_S]), .nhr_w_write_i(wr[PORT_W]),
		.nhr_e_write_i(wr[PORT_E]), .nhr_l_write_i(wr[PORT_L]),
		.nhr_n_release_i(rel[PORT_N]), .nhr_s_release_i(rel[PORT_S]),
		.nhr_w_release_i(rel[PORT_W]), .nhr_e_release_i(rel[PORT_E]),
		.nhr_l_release_i(rel[PORT_L]),
		.rr_n_register_change_order_i(co[PORT_N]), .rr_s_register_change_order_i(co[PORT_S]),
		.rr_w_register_change_order_i(co[PORT_W]), .rr_e_register_change_order_i(co[PORT_E]),
		.rr_l_register_change_order_i(co[PORT_L]),
		.rrp_n_priority_o(grants[4:0]), .rrp_s_priority_o(grants[9:5]),
		.rrp_w_priority_o(grants[14:10]), .rrp_e_priority_o(grants[19:15]),
		.rrp_l_priority_o(grants[24:20]),
		.rrp_n_priority_to_cs_o(to_cs[PORT_N]), .rrp_s_priority_to_cs_o(to_cs[PORT_S]),
		.rrp_w_priority_to_cs_o(to_cs[PORT_W]), .rrp_e_priority_to_cs_o(to_cs[PORT_E]),
		.rrp_l_priority_to_cs_o(to_cs[PORT_L])
	);

	arbiter_checker i_checker (
		.clk(clk), .reset_i(reset), .router_i(router), .header_i(headers),
		.write_i(wr), .release_i(rel), .change_order_i(co),
		.grant_i(grants), .to_cs_i(to_cs),
		.exp_valid_i(exp_valid), .exp_grant_i(exp_grant), .test_name_i(test_name),
		.check_count_o(check_count), .error_count_o(error_count)
	);

	function automatic logic [NUM_PORTS*NUM_PORTS-1:0] pack_grants(
		input logic [NUM_PORTS-1:0] n, input logic [NUM_PORTS-1:0] s,
		input logic [NUM_PORTS-1:0] w, input logic [NUM_PORTS-1:0] e,
		input logic [NUM_PORTS-1:0] l
	);
		return {l, e, w, s, n};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task add_row(input logic [8*12-1:0] name, input logic [ADDR_W-1:0] rtr,
		input logic [NUM_PORTS*ADDR_W-1:0] hdr, input logic [NUM_PORTS-1:0] w_mask,
		input logic [NUM_PORTS-1:0] r_mask, input logic [NUM_PORTS-1:0] c_mask,
		input logic [NUM_PORTS*NUM_PORTS-1:0] exp);
		tbl_name[row_fill]   = name;
		tbl_router[row_fill] = rtr;
		tbl_hdr[row_fill]    = hdr;
		tbl_wr[row_fill]     = w_mask;
		tbl_rel[row_fill]    = r_mask;
		tbl_co[row_fill]     = c_mask;
		tbl_exp[row_fill]    = exp;
		row_fill++;
	endtask

	// ########################################
	// Header bytes are l, e, w, s, n from the left. Mask bit 0 is north.
	// Router sits at Y=2, X=2.
	task fill_table();
		row_fill = 0;
		add_row("reset_idle", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000));
		add_row("yx_south", 8'h22, 40'h00_00_00_00_32, 5'b00001, 5'b00000, 5'b00000,
			pack_grants(5'b00000, 5'b00001, 5'b00000, 5'b00000, 5'b00000));
		add_row("yx_north", 8'h22, 40'h00_00_00_12_00, 5'b00010, 5'b00000, 5'b00000,
			pack_grants(5'b00010, 5'b00001, 5'b00000, 5'b00000, 5'b00000));
		add_row("yx_east", 8'h22, 40'h00_00_23_00_00, 5'b00100, 5'b00000, 5'b00000,
			pack_grants(5'b00010, 5'b00001, 5'b00000, 5'b00100, 5'b00000));
		add_row("yx_west", 8'h22, 40'h00_21_00_00_00, 5'b01000, 5'b00000, 5'b00000,
			pack_grants(5'b00010, 5'b00001, 5'b01000, 5'b00100, 5'b00000));
		add_row("yx_local", 8'h22, 40'h00_00_00_00_22, 5'b00001, 5'b00000, 5'b00000,
			pack_grants(5'b00010, 5'b00000, 5'b01000, 5'b00100, 5'b00001));
		add_row("release_all", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b11111, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000));
		// Four inputs heading east, then the east pointer is rotated.
		add_row("rr_load", 8'h22, 40'h23_00_23_23_23, 5'b10111, 5'b00000, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00001, 5'b00000));
		add_row("rr_step1", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b01000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00010, 5'b00000));
		add_row("rr_step2", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b01000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00100, 5'b00000));
		add_row("rr_step3", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b01000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b10000, 5'b00000));
		add_row("rr_wrap", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b01000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00001, 5'b00000));
		add_row("rel_next", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00001, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00010, 5'b00000));
		add_row("wr_over_rel", 8'h22, 40'h00_00_00_23_00, 5'b00010, 5'b00010, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00010, 5'b00000));
		// West steps while idle, so south beats north on the next row.
		add_row("idle_co", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00000, 5'b00100,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00010, 5'b00000));
		// East to east and local to local are U-turns.
		add_row("uturn_mask", 8'h22, 40'h22_23_00_21_21, 5'b11011, 5'b00000, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00010, 5'b00100, 5'b00000));
		add_row("uturn_only", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b00110, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00001, 5'b00000, 5'b00000));
		add_row("release_end", 8'h22, 40'h00_00_00_00_00, 5'b00000, 5'b11111, 5'b00000,
			pack_grants(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000));
	endtask

	task apply_row(input int r);
		router    = tbl_router[r];
		headers   = tbl_hdr[r];
		wr        = tbl_wr[r];
		rel       = tbl_rel[r];
		co        = tbl_co[r];
		exp_grant = tbl_exp[r];
		test_name = tbl_name[r];
		exp_valid = 1'b1;
	endtask

	// Each strobe is high with a probability of one quarter.
	task drive_random();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		rng_state = xorshift32(rng_state);
		r1 = rng_state;
		rng_state = xorshift32(rng_state);
		r2 = rng_state;
		rng_state = xorshift32(rng_state);
		r3 = rng_state;
		router  = r3[15:8];
		headers = {r2, r3[7:0]};
		wr      = r1[4:0] & r1[9:5];
		rel     = r1[14:10] & r1[19:15];
		co      = r1[24:20] & r1[29:25];
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		router    = '0;
		headers   = '0;
		wr        = '0;
		rel       = '0;
		co        = '0;
		exp_valid = 1'b0;
		exp_grant = '0;
		test_name = "reset";
		rng_state = 32'd68768;
		fill_table();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
			@(negedge clk);
		end
		exp_valid = 1'b0;
		test_name = "random";
		for (int i = 0; i < NUM_RANDOM; i++) begin
			drive_random();
			@(negedge clk);
		end
		wr  = '0;
		rel = '0;
		co  = '0;
		repeat (2) @(negedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

//--- verilog/arbiter.sv
`timescale 1ns/1ns

module arbiter
	import noc_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset_i,

	input  logic [ADDR_W-1:0]    yx_addr_router_i,

	input  logic [ADDR_W-1:0]    yx_n_addr_header_i,
	input  logic [ADDR_W-1:0]    yx_s_addr_header_i,
	input  logic [ADDR_W-1:0]    yx_w_addr_header_i,
	input  logic [ADDR_W-1:0]    yx_e_addr_header_i,
	input  logic [ADDR_W-1:0]    yx_l_addr_header_i,

	input  logic                 nhr_n_write_i,
	input  logic                 nhr_s_write_i,
	input  logic                 nhr_w_write_i,
	input  logic                 nhr_e_write_i,
	input  logic                 nhr_l_write_i,

	input  logic                 nhr_n_release_i,
	input  logic                 nhr_s_release_i,
	input  logic                 nhr_w_release_i,
	input  logic                 nhr_e_release_i,
	input  logic                 nhr_l_release_i,

	input  logic                 rr_n_register_change_order_i,
	input  logic                 rr_s_register_change_order_i,
	input  logic                 rr_w_register_change_order_i,
	input  logic                 rr_e_register_change_order_i,
	input  logic                 rr_l_register_change_order_i,

	output logic [NUM_PORTS-1:0] rrp_n_priority_o,
	output logic [NUM_PORTS-1:0] rrp_s_priority_o,
	output logic [NUM_PORTS-1:0] rrp_w_priority_o,
	output logic [NUM_PORTS-1:0] rrp_e_priority_o,
	output logic [NUM_PORTS-1:0] rrp_l_priority_o,

	output logic                 rrp_n_priority_to_cs_o,
	output logic                 rrp_s_priority_to_cs_o,
	output logic                 rrp_w_priority_to_cs_o,
	output logic                 rrp_e_priority_to_cs_o,
	output logic                 rrp_l_priority_to_cs_o
);

	logic [PORT_CODE_W-1:0] nhr_n_addr;
	logic [PORT_CODE_W-1:0] nhr_s_addr;
	logic [PORT_CODE_W-1:0] nhr_w_addr;
	logic [PORT_CODE_W-1:0] nhr_e_addr;
	logic [PORT_CODE_W-1:0] nhr_l_addr;

	// ########################################
	// Input side, one held route per input.
	route_register i_route_n (
		.clk(clk), .reset_i(reset_i), .yx_addr_router_i(yx_addr_router_i),
		.yx_addr_header_i(yx_n_addr_header_i), .nhr_write_i(nhr_n_write_i),
		.nhr_release_i(nhr_n_release_i), .nhr_address_o(nhr_n_addr)
	);

	route_register i_route_s (
		.clk(clk), .reset_i(reset_i), .yx_addr_router_i(yx_addr_router_i),
		.yx_addr_header_i(yx_s_addr_header_i), .nhr_write_i(nhr_s_write_i),
		.nhr_release_i(nhr_s_release_i), .nhr_address_o(nhr_s_addr)
	);

	route_register i_route_w (
		.clk(clk), .reset_i(reset_i), .yx_addr_router_i(yx_addr_router_i),
		.yx_addr_header_i(yx_w_addr_header_i), .nhr_write_i(nhr_w_write_i),
		.nhr_release_i(nhr_w_release_i), .nhr_address_o(nhr_w_addr)
	);

	route_register i_route_e (
		.clk(clk), .reset_i(reset_i), .yx_addr_router_i(yx_addr_router_i),
		.yx_addr_header_i(yx_e_addr_header_i), .nhr_write_i(nhr_e_write_i),
		.nhr_release_i(nhr_e_release_i), .nhr_address_o(nhr_e_addr)
	);

	route_register i_route_l (
		.clk(clk), .reset_i(reset_i), .yx_addr_router_i(yx_addr_router_i),
		.yx_addr_header_i(yx_l_addr_header_i), .nhr_write_i(nhr_l_write_i),
		.nhr_release_i(nhr_l_release_i), .nhr_address_o(nhr_l_addr)
	);

	// ########################################
	// Output side, every arbiter sees all five routes.
	rr_output_arbiter #(.OUT_PORT(PORT_N)) i_arb_n (
		.clk(clk), .reset_i(reset_i),
		.nexthop_n_i(nhr_n_addr), .nexthop_s_i(nhr_s_addr), .nexthop_w_i(nhr_w_addr),
		.nexthop_e_i(nhr_e_addr), .nexthop_l_i(nhr_l_addr),
		.rr_register_change_order_i(rr_n_register_change_order_i),
		.rrp_priority_o(rrp_n_priority_o), .rrp_priority_to_cs_o(rrp_n_priority_to_cs_o)
	);

	rr_output_arbiter #(.OUT_PORT(PORT_S)) i_arb_s (
		.clk(clk), .reset_i(reset_i),
		.nexthop_n_i(nhr_n_addr), .nexthop_s_i(nhr_s_addr), .nexthop_w_i(nhr_w_addr),
		.nexthop_e_i(nhr_e_addr), .nexthop_l_i(nhr_l_addr),
		.rr_register_change_order_i(rr_s_register_change_order_i),
		.rrp_priority_o(rrp_s_priority_o), .rrp_priority_to_cs_o(rrp_s_priority_to_cs_o)
	);

	rr_output_arbiter #(.OUT_PORT(PORT_W)) i_arb_w (
		.clk(clk), .reset_i(reset_i),
		.nexthop_n_i(nhr_n_addr), .nexthop_s_i(nhr_s_addr), .nexthop_w_i(nhr_w_addr),
		.nexthop_e_i(nhr_e_addr), .nexthop_l_i(nhr_l_addr),
		.rr_register_change_order_i(rr_w_register_change_order_i),
		.rrp_priority_o(rrp_w_priority_o), .rrp_priority_to_cs_o(rrp_w_priority_to_cs_o)
	);

	rr_output_arbiter #(.OUT_PORT(PORT_E)) i_arb_e (
		.clk(clk), .reset_i(reset_i),
		.nexthop_n_i(nhr_n_addr), .nexthop_s_i(nhr_s_addr), .nexthop_w_i(nhr_w_addr),
		.nexthop_e_i(nhr_e_addr), .nexthop_l_i(nhr_l_addr),
		.rr_register_change_order_i(rr_e_register_change_order_i),
		.rrp_priority_o(rrp_e_priority_o), .rrp_priority_to_cs_o(rrp_e_priority_to_cs_o)
	);

	rr_output_arbiter #(.OUT_PORT(PORT_L)) i_arb_l (
		.clk(clk), .reset_i(reset_i),
		.nexthop_n_i(nhr_n_addr), .nexthop_s_i(nhr_s_addr), .nexthop_w_i(nhr_w_addr),
		.nexthop_e_i(nhr_e_addr), .nexthop_l_i(nhr_l_addr),
		.rr_register_change_order_i(rr_l_register_change_order_i),
		.rrp_priority_o(rrp_l_priority_o), .rrp_priority_to_cs_o(rrp_l_priority_to_cs_o)
	);

endmodule

//--- verilog/noc_pkg.sv
package noc_pkg;

	// Port count of the mesh router.
	localparam int NUM_PORTS = 5;

	// Width of a port code. West already owns the name PORT_W.
	localparam int PORT_CODE_W = 3;

	// Port codes, also the bit order of every grant and request vector.
	localparam logic [PORT_CODE_W-1:0] PORT_N = 3'd0;
	localparam logic [PORT_CODE_W-1:0] PORT_S = 3'd1;
	localparam logic [PORT_CODE_W-1:0] PORT_W = 3'd2;
	localparam logic [PORT_CODE_W-1:0] PORT_E = 3'd3;
	localparam logic [PORT_CODE_W-1:0] PORT_L = 3'd4;

	// No route held.
	localparam logic [PORT_CODE_W-1:0] PORT_NONE = 3'd7;

	// Router and header addresses, Y in the upper half, X in the lower half.
	localparam int ADDR_W  = 8;
	localparam int COORD_W = 4;

endpackage

//--- verilog/route_register.sv
`timescale 1ns/1ns

module route_register
	import noc_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic [ADDR_W-1:0]      yx_addr_router_i,
	input  logic [ADDR_W-1:0]      yx_addr_header_i,
	input  logic                   nhr_write_i,
	input  logic                   nhr_release_i,
	output logic [PORT_CODE_W-1:0] nhr_address_o
);

	logic [COORD_W-1:0]     router_y;
	logic [COORD_W-1:0]     router_x;
	logic [COORD_W-1:0]     header_y;
	logic [COORD_W-1:0]     header_x;
	logic [PORT_CODE_W-1:0] yx_route;
	logic [PORT_CODE_W-1:0] route_q;
	logic                   route_valid_q;

	assign router_y = yx_addr_router_i[ADDR_W-1 -: COORD_W];
	assign router_x = yx_addr_router_i[COORD_W-1:0];
	assign header_y = yx_addr_header_i[ADDR_W-1 -: COORD_W];
	assign header_x = yx_addr_header_i[COORD_W-1:0];

	// ########################################
	// YX routing, Y is resolved first.
	always_comb begin
		if (header_y > router_y) begin
			yx_route = PORT_S;
		end else if (header_y < router_y) begin
			yx_route = PORT_N;
		end else if (header_x > router_x) begin
			yx_route = PORT_E;
		end else if (header_x < router_x) begin
			yx_route = PORT_W;
		end else begin
			yx_route = PORT_L;
		end
	end

	// ########################################
	// Next-hop register, write wins over release.
	always_ff @(posedge clk) begin
		if (nhr_write_i) begin
			route_q <= yx_route;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			route_valid_q <= 1'b0;
		end else if (nhr_write_i) begin
			route_valid_q <= 1'b1;
		end else if (nhr_release_i) begin
			route_valid_q <= 1'b0;
		end
	end

	assign nhr_address_o = route_valid_q ? route_q : PORT_NONE;

endmodule

//--- verilog/rr_output_arbiter.sv
`timescale 1ns/1ns

module rr_output_arbiter
	import noc_pkg::*;
#(
	parameter logic [PORT_CODE_W-1:0] OUT_PORT = PORT_N
) (
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic [PORT_CODE_W-1:0] nexthop_n_i,
	input  logic [PORT_CODE_W-1:0] nexthop_s_i,
	input  logic [PORT_CODE_W-1:0] nexthop_w_i,
	input  logic [PORT_CODE_W-1:0] nexthop_e_i,
	input  logic [PORT_CODE_W-1:0] nexthop_l_i,
	input  logic                   rr_register_change_order_i,
	output logic [NUM_PORTS-1:0]   rrp_priority_o,
	output logic                   rrp_priority_to_cs_o
);

	logic [PORT_CODE_W-1:0] nexthop [NUM_PORTS];
	logic [NUM_PORTS-1:0]   request;
	logic [NUM_PORTS-1:0]   grant;
	logic [PORT_CODE_W-1:0] pointer;

	assign nexthop[PORT_N] = nexthop_n_i;
	assign nexthop[PORT_S] = nexthop_s_i;
	assign nexthop[PORT_W] = nexthop_w_i;
	assign nexthop[PORT_E] = nexthop_e_i;
	assign nexthop[PORT_L] = nexthop_l_i;

	// ########################################
	// Requests, own direction masked.
	always_comb begin
		for (int p = 0; p < NUM_PORTS; p++) begin
			request[p] = (nexthop[p] == OUT_PORT) && (p != int'(OUT_PORT));
		end
	end

	// ########################################
	// First requester at or after the pointer, circular.
	always_comb begin
		int   idx;
		logic found;
		grant = '0;
		found = 1'b0;
		for (int k = 0; k < NUM_PORTS; k++) begin
			idx = int'(pointer) + k;
			if (idx >= NUM_PORTS) begin
				idx = idx - NUM_PORTS;
			end
			if (!found && request[idx]) begin
				grant[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	rr_priority_register i_rr_priority_register (
		.clk            (clk),
		.reset_i        (reset_i),
		.change_order_i (rr_register_change_order_i),
		.grant_i        (grant),
		.pointer_o      (pointer)
	);

	assign rrp_priority_o       = grant;
	assign rrp_priority_to_cs_o = |request;

endmodule

//--- verilog/rr_priority_register.sv
`timescale 1ns/1ns

module rr_priority_register
	import noc_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_i,
	input  logic                   change_order_i,
	input  logic [NUM_PORTS-1:0]   grant_i,
	output logic [PORT_CODE_W-1:0] pointer_o
);

	logic [PORT_CODE_W-1:0] grant_idx;
	logic [PORT_CODE_W-1:0] step_base;
	logic [PORT_CODE_W-1:0] next_pointer;

	// Index of the granted input, the grant is one-hot.
	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (grant_i[i]) begin
				grant_idx = PORT_CODE_W'(i);
			end
		end
	end

	// Step past the winner, or past the current pointer when idle.
	assign step_base = (|grant_i) ? grant_idx : pointer_o;

	assign next_pointer = (step_base == PORT_CODE_W'(NUM_PORTS - 1)) ? '0
		: step_base + 1'b1;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pointer_o <= '0;
		end else if (change_order_i) begin
			pointer_o <= next_pointer;
		end
	end

endmodule
